// ==== pe_defs.svh ====
`ifndef PE_DEFS_SVH
`define PE_DEFS_SVH

// ======================================================================
// datapath widths and scratchpad depths
// ======================================================================
`define PE_DWD          16      // pixel, weight and psum
`define PE_WB_DWD       32
`define PE_WB_AWD       8
`define PE_PAD_AWD      6       // pad request address width

`define PE_IPAD_SIZE    32
`define PE_WPAD_SIZE    16
`define PE_PPAD_SIZE    32

// ======================================================================
// bus address map, byte addresses
// ======================================================================
`define PE_ADR_CFG      8'h00
`define PE_ADR_CTRL     8'h04   // write starts, read gives status
`define PE_ADR_WPAD     8'h40
`define PE_ADR_IPAD     8'h80
`define PE_ADR_PPAD     8'hC0
`define PE_ADR_REGION   8'hC0   // upper bits select the pad region

`endif

// ==== pe_pkg.sv ====
`default_nettype none

`include "pe_defs.svh"

package pe_pkg;

    typedef enum logic {
        SIGNED_T,
        UNSIGNED_T
    } pe_num_t;

    typedef enum logic {
        ZERO_INIT,
        FROM_BUF        // start from the psum already in ppad
    } pe_psum_init_t;

    typedef enum logic [2:0] {
        IDLE,
        PRELOAD,
        MAC,
        DRAIN,
        WRITE,
        DONE
    } pe_state_t;

    // configuration word, r_len sits in the low bits
    typedef struct packed {
        logic [15:0]   rsvd;
        pe_psum_init_t init_mode;
        pe_num_t       num_t;
        logic [5:0]    w_len;
        logic [2:0]    stride;
        logic [4:0]    r_len;
    } pe_cfg_t;

    typedef struct packed {
        logic [15:0]          rsvd;
        logic [`PE_DWD-1:0]   val;
    } pe_pix_t;

    // one bus write word, two decodings
    typedef union packed {
        pe_cfg_t cfg;
        pe_pix_t pix;
    } pe_wb_word_u;

    typedef struct packed {
        logic                   we;
        logic                   re;
        logic [`PE_PAD_AWD-1:0] waddr;
        logic [`PE_PAD_AWD-1:0] raddr;
        logic [`PE_DWD-1:0]     wdata;
    } pe_pad_req_t;

endpackage

`default_nettype wire

// ==== spad_rf.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pe_defs.svh"

module spad_rf import pe_pkg::*; #(
    parameter int DEPTH = 32,
    parameter int WIDTH = `PE_DWD
) (
    input  wire logic        i_clk,
    input  wire logic        i_rstn,
    input  wire pe_pad_req_t i_req,
    output logic [WIDTH-1:0] o_rdata
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];

    // one write port, one registered read port
    always_ff @(posedge i_clk) begin
        if (i_req.we) begin
            mem[i_req.waddr[AW-1:0]] <= i_req.wdata;
        end
        if (i_req.re) begin
            o_rdata <= mem[i_req.raddr[AW-1:0]];  // valid next cycle
        end
    end

    // requesters must stay inside the pad, upper address bits are dropped
    a_addr_range: assert property (
        @(posedge i_clk) disable iff (!i_rstn)
        (i_req.we |-> (i_req.waddr < DEPTH)) and (i_req.re |-> (i_req.raddr < DEPTH))
    ) else $error("spad_rf: address out of range, depth %0d", DEPTH);

endmodule

`default_nettype wire

// ==== mac_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pe_defs.svh"

module mac_unit import pe_pkg::*; (
    input  wire logic               i_clk,
    input  wire logic               i_rstn,
    input  wire pe_num_t            i_num_t,
    input  wire logic               i_clr,
    input  wire logic               i_load,
    input  wire logic [`PE_DWD-1:0] i_load_val,
    input  wire logic               i_en,
    input  wire logic [`PE_DWD-1:0] i_a,      // pixel
    input  wire logic [`PE_DWD-1:0] i_b,      // weight
    output logic [`PE_DWD-1:0]      o_acc
);

    localparam int DW = `PE_DWD;

    logic signed [2*DW-1:0] prod_s;
    logic [2*DW-1:0]        prod_u;
    logic [DW-1:0]          prod_lo;

    // full width product, then keep the low word
    assign prod_s  = $signed(i_a) * $signed(i_b);
    assign prod_u  = i_a * i_b;
    assign prod_lo = (i_num_t == SIGNED_T) ? prod_s[DW-1:0] : prod_u[DW-1:0];

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_acc <= '0;
        end else if (i_clr) begin
            o_acc <= '0;
        end else if (i_load) begin
            o_acc <= i_load_val;          // initial psum
        end else if (i_en) begin
            o_acc <= o_acc + prod_lo;     // wraps mod 2^16
        end
    end

endmodule

`default_nettype wire

// ==== pe_index_cnt.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pe_defs.svh"

module pe_index_cnt import pe_pkg::*; (
    input  wire logic                  i_clk,
    input  wire logic                  i_rstn,
    input  wire pe_cfg_t               i_cfg,
    input  wire logic                  i_clr,
    input  wire logic                  i_step_r,
    input  wire logic                  i_step_j,
    output logic [4:0]                 o_r_idx,
    output logic [`PE_PAD_AWD-1:0]     o_j_idx,
    output logic [`PE_PAD_AWD-1:0]     o_x_addr,
    output logic                       o_last_r,
    output logic                       o_last_j
);

    logic [4:0]             r_q;
    logic [`PE_PAD_AWD-1:0] j_q;
    logic [`PE_PAD_AWD-1:0] base_q;     // first pixel of current window
    logic [2:0]             stride_eff;
    logic [5:0]             span;
    logic [5:0]             j_last;     // E - 1

    // a zero stride behaves as one
    assign stride_eff = (i_cfg.stride == 3'd0) ? 3'd1 : i_cfg.stride;
    assign span       = i_cfg.w_len - {1'b0, i_cfg.r_len};
    assign j_last     = span / {3'b000, stride_eff};

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_q    <= '0;
            j_q    <= '0;
            base_q <= '0;
        end else if (i_clr) begin
            r_q    <= '0;
            j_q    <= '0;
            base_q <= '0;
        end else if (i_step_j) begin
            r_q    <= '0;                           // next window
            j_q    <= j_q + 6'd1;
            base_q <= base_q + {3'b000, stride_eff};
        end else if (i_step_r) begin
            r_q    <= r_q + 5'd1;
        end
    end

    assign o_r_idx  = r_q;
    assign o_j_idx  = j_q;
    assign o_x_addr = base_q + {1'b0, r_q};
    assign o_last_r = (r_q == i_cfg.r_len - 5'd1);
    assign o_last_j = (j_q == j_last);

    // window must never run past the loaded input row
    a_x_in_row: assert property (
        @(posedge i_clk) disable iff (!i_rstn)
        (i_step_r || i_step_j) |-> (o_x_addr < i_cfg.w_len)
    ) else $error("pe_index_cnt: x address %0h beyond w_len", o_x_addr);

endmodule

`default_nettype wire

// ==== pe_ctrl_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module pe_ctrl_fsm import pe_pkg::*; (
    input  wire logic    i_clk,
    input  wire logic    i_rstn,
    input  wire pe_cfg_t i_cfg,
    input  wire logic    i_start,
    input  wire logic    i_last_r,
    input  wire logic    i_last_j,
    output logic         o_busy,
    output logic         o_done,
    output logic         o_cnt_clr,
    output logic         o_step_r,
    output logic         o_step_j,
    output logic         o_ipad_re,
    output logic         o_wpad_re,
    output logic         o_ppad_re,
    output logic         o_ppad_we,
    output logic         o_mac_clr,
    output logic         o_mac_load,
    output logic         o_mac_en
);

    pe_state_t state_q;
    pe_state_t state_d;
    logic      ph_q;        // second preload cycle
    logic      from_buf;

    assign from_buf = (i_cfg.init_mode == FROM_BUF);

    // ==================================================================
    // state register
    // ==================================================================
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            state_q  <= IDLE;
            ph_q     <= 1'b0;
            o_mac_en <= 1'b0;
        end else begin
            state_q  <= state_d;
            ph_q     <= (state_q == PRELOAD) && !ph_q;
            o_mac_en <= (state_q == MAC);   // pad data lands one cycle later
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (i_start) state_d = PRELOAD;
            PRELOAD: if (ph_q) state_d = MAC;
            MAC:     if (i_last_r) state_d = DRAIN;
            DRAIN:   state_d = WRITE;
            WRITE:   state_d = i_last_j ? DONE : PRELOAD;
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    // ==================================================================
    // strobes
    // ==================================================================
    assign o_busy     = (state_q != IDLE);
    assign o_done     = (state_q == DONE);
    assign o_cnt_clr  = (state_q == IDLE) && i_start;
    assign o_step_r   = (state_q == MAC) && !i_last_r;
    assign o_step_j   = (state_q == WRITE) && !i_last_j;
    assign o_ipad_re  = (state_q == MAC);
    assign o_wpad_re  = (state_q == MAC);
    assign o_ppad_re  = (state_q == PRELOAD) && !ph_q && from_buf;
    assign o_mac_load = (state_q == PRELOAD) && ph_q && from_buf;
    assign o_mac_clr  = (state_q == PRELOAD) && ph_q && !from_buf;
    assign o_ppad_we  = (state_q == WRITE);  // acc into ppad[j]

    // host config must describe at least one full window
    a_cfg_on_start: assert property (
        @(posedge i_clk) disable iff (!i_rstn)
        ((state_q == IDLE) && i_start) |->
            ((i_cfg.r_len != 5'd0) && ({1'b0, i_cfg.r_len} <= i_cfg.w_len))
    ) else $error("pe_ctrl_fsm: bad config r_len %0h w_len %0h", i_cfg.r_len, i_cfg.w_len);

endmodule

`default_nettype wire

// ==== pe_wb_slave.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pe_defs.svh"

module pe_wb_slave import pe_pkg::*; (
    input  wire logic                  i_clk,
    input  wire logic                  i_rstn,
    input  wire logic                  i_wb_cyc,
    input  wire logic                  i_wb_stb,
    input  wire logic                  i_wb_we,
    input  wire logic [`PE_WB_AWD-1:0] i_wb_adr,
    input  wire logic [`PE_WB_DWD-1:0] i_wb_dat,
    input  wire logic                  i_busy,
    input  wire logic                  i_done,
    input  wire logic [`PE_DWD-1:0]    i_ppad_rdata,
    output logic [`PE_WB_DWD-1:0]      o_wb_dat,
    output logic                       o_wb_ack,
    output pe_cfg_t                    o_cfg,
    output logic                       o_start,
    output pe_pad_req_t                o_wpad_req,
    output pe_pad_req_t                o_ipad_req,
    output pe_pad_req_t                o_ppad_req
);

    pe_wb_word_u            wr_word;
    logic                   req;
    logic                   wr_req;
    logic                   rd_req;
    logic                   is_cfg;
    logic                   is_ctrl;
    logic                   is_wpad;
    logic                   is_ipad;
    logic                   is_ppad;
    logic [`PE_PAD_AWD-1:0] pad_idx;
    logic                   done_q;
    logic                   ppad_sel_q;     // read data comes from ppad
    logic [`PE_WB_DWD-1:0]  dat_q;

    // ==================================================================
    // decode
    // ==================================================================
    assign wr_word = i_wb_dat;
    assign req     = i_wb_cyc && i_wb_stb && !o_wb_ack;   // one ack per access
    assign wr_req  = req && i_wb_we;
    assign rd_req  = req && !i_wb_we;
    assign is_cfg  = (i_wb_adr == `PE_ADR_CFG);
    assign is_ctrl = (i_wb_adr == `PE_ADR_CTRL);
    assign is_wpad = ((i_wb_adr & `PE_ADR_REGION) == `PE_ADR_WPAD);
    assign is_ipad = ((i_wb_adr & `PE_ADR_REGION) == `PE_ADR_IPAD);
    assign is_ppad = ((i_wb_adr & `PE_ADR_REGION) == `PE_ADR_PPAD);
    assign pad_idx = {2'b00, i_wb_adr[5:2]};            // word index

    // pad writes are dropped while a run owns the pads
    always_comb begin
        o_wpad_req       = '0;
        o_wpad_req.we    = wr_req && is_wpad && !i_busy;
        o_wpad_req.waddr = pad_idx;
        o_wpad_req.wdata = wr_word.pix.val;

        o_ipad_req       = '0;
        o_ipad_req.we    = wr_req && is_ipad && !i_busy;
        o_ipad_req.waddr = pad_idx;
        o_ipad_req.wdata = wr_word.pix.val;

        o_ppad_req       = '0;
        o_ppad_req.we    = wr_req && is_ppad && !i_busy;
        o_ppad_req.re    = rd_req && is_ppad && !i_busy;
        o_ppad_req.waddr = pad_idx;
        o_ppad_req.raddr = pad_idx;
        o_ppad_req.wdata = wr_word.pix.val;
    end

    // ==================================================================
    // registers
    // ==================================================================
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_wb_ack   <= 1'b0;
            o_start    <= 1'b0;
            o_cfg      <= '0;
            done_q     <= 1'b0;
            ppad_sel_q <= 1'b0;
        end else begin
            o_wb_ack   <= req;
            o_start    <= wr_req && is_ctrl && !i_busy;   // ignored while busy
            ppad_sel_q <= rd_req && is_ppad && !i_busy;
            if (wr_req && is_cfg && !i_busy) begin
                o_cfg <= wr_word.cfg;
            end
            if (i_done) begin
                done_q <= 1'b1;                 // sticky
            end else if (o_start) begin
                done_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (rd_req) begin
            if (is_cfg) begin
                dat_q <= o_cfg;
            end else if (is_ctrl) begin
                dat_q <= {30'b0, done_q, i_busy};   // status
            end else begin
                dat_q <= '0;
            end
        end
    end

    assign o_wb_dat = ppad_sel_q ? {{(`PE_WB_DWD-`PE_DWD){1'b0}}, i_ppad_rdata} : dat_q;

    // a start pulse has to meet an idle FSM
    a_start_when_idle: assert property (
        @(posedge i_clk) disable iff (!i_rstn)
        o_start |-> !i_busy
    ) else $error("pe_wb_slave: start pulse while the run is busy");

endmodule

`default_nettype wire

// ==== pe_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pe_defs.svh"

module pe_top import pe_pkg::*; (
    input  wire logic                  i_clk,
    input  wire logic                  i_rstn,
    input  wire logic                  i_wb_cyc,
    input  wire logic                  i_wb_stb,
    input  wire logic                  i_wb_we,
    input  wire logic [`PE_WB_AWD-1:0] i_wb_adr,
    input  wire logic [`PE_WB_DWD-1:0] i_wb_dat,
    output logic [`PE_WB_DWD-1:0]      o_wb_dat,
    output logic                       o_wb_ack,
    output logic                       o_irq
);

    pe_cfg_t                cfg;
    logic                   start;
    logic                   busy;
    logic                   cnt_clr;
    logic                   step_r;
    logic                   step_j;
    logic                   last_r;
    logic                   last_j;
    logic                   ipad_re;
    logic                   wpad_re;
    logic                   ppad_re;
    logic                   ppad_we;
    logic                   mac_clr;
    logic                   mac_load;
    logic                   mac_en;
    logic [4:0]             r_idx;
    logic [`PE_PAD_AWD-1:0] j_idx;
    logic [`PE_PAD_AWD-1:0] x_addr;
    logic [`PE_DWD-1:0]     ipad_rdata;
    logic [`PE_DWD-1:0]     wpad_rdata;
    logic [`PE_DWD-1:0]     ppad_rdata;
    logic [`PE_DWD-1:0]     acc;
    pe_pad_req_t            wpad_bus;
    pe_pad_req_t            ipad_bus;
    pe_pad_req_t            ppad_bus;
    pe_pad_req_t            wpad_dp;
    pe_pad_req_t            ipad_dp;
    pe_pad_req_t            ppad_dp;

    pe_wb_slave u_slave (
        .i_clk(i_clk), .i_rstn(i_rstn),
        .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
        .i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat),
        .i_busy(busy), .i_done(o_irq), .i_ppad_rdata(ppad_rdata),
        .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack), .o_cfg(cfg), .o_start(start),
        .o_wpad_req(wpad_bus), .o_ipad_req(ipad_bus), .o_ppad_req(ppad_bus)
    );

    pe_ctrl_fsm u_fsm (
        .i_clk(i_clk), .i_rstn(i_rstn), .i_cfg(cfg), .i_start(start),
        .i_last_r(last_r), .i_last_j(last_j),
        .o_busy(busy), .o_done(o_irq), .o_cnt_clr(cnt_clr),
        .o_step_r(step_r), .o_step_j(step_j),
        .o_ipad_re(ipad_re), .o_wpad_re(wpad_re), .o_ppad_re(ppad_re), .o_ppad_we(ppad_we),
        .o_mac_clr(mac_clr), .o_mac_load(mac_load), .o_mac_en(mac_en)
    );

    pe_index_cnt u_cnt (
        .i_clk(i_clk), .i_rstn(i_rstn), .i_cfg(cfg),
        .i_clr(cnt_clr), .i_step_r(step_r), .i_step_j(step_j),
        .o_r_idx(r_idx), .o_j_idx(j_idx), .o_x_addr(x_addr),
        .o_last_r(last_r), .o_last_j(last_j)
    );

    mac_unit u_mac (
        .i_clk(i_clk), .i_rstn(i_rstn), .i_num_t(cfg.num_t),
        .i_clr(mac_clr), .i_load(mac_load), .i_load_val(ppad_rdata),
        .i_en(mac_en), .i_a(ipad_rdata), .i_b(wpad_rdata), .o_acc(acc)
    );

    // datapath side of each pad, read ports plus ppad write-back
    always_comb begin
        ipad_dp       = '0;
        ipad_dp.re    = ipad_re;
        ipad_dp.raddr = x_addr;

        wpad_dp       = '0;
        wpad_dp.re    = wpad_re;
        wpad_dp.raddr = {1'b0, r_idx};

        ppad_dp       = '0;
        ppad_dp.re    = ppad_re;
        ppad_dp.raddr = j_idx;
        ppad_dp.we    = ppad_we;
        ppad_dp.waddr = j_idx;
        ppad_dp.wdata = acc;
    end

    spad_rf #(.DEPTH(`PE_IPAD_SIZE), .WIDTH(`PE_DWD)) u_ipad (
        .i_clk(i_clk), .i_rstn(i_rstn),
        .i_req(busy ? ipad_dp : ipad_bus), .o_rdata(ipad_rdata)
    );

    spad_rf #(.DEPTH(`PE_WPAD_SIZE), .WIDTH(`PE_DWD)) u_wpad (
        .i_clk(i_clk), .i_rstn(i_rstn),
        .i_req(busy ? wpad_dp : wpad_bus), .o_rdata(wpad_rdata)
    );

    spad_rf #(.DEPTH(`PE_PPAD_SIZE), .WIDTH(`PE_DWD)) u_ppad (
        .i_clk(i_clk), .i_rstn(i_rstn),
        .i_req(busy ? ppad_dp : ppad_bus), .o_rdata(ppad_rdata)
    );

endmodule

`default_nettype wire

// ==== tb_pe_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pe_defs.svh"

module tb_pe_top import pe_pkg::*; ();

    localparam int RUN_CYC        = 14*(3+4) + 7*(4+4) + 4*(5+4);  // sum of E*(R+4)
    localparam int BUS_CYC        = 3*200;                          // about 200 accesses
    localparam int CYCLE_LIMIT    = 4*(RUN_CYC + BUS_CYC + 8);
    localparam int ACK_WAIT       = 8;
    localparam int PAD_BUS_WORDS  = 16;     // bus reaches 16 words per pad

    logic                  i_clk;
    logic                  i_rstn;
    logic                  i_wb_cyc;
    logic                  i_wb_stb;
    logic                  i_wb_we;
    logic [`PE_WB_AWD-1:0] i_wb_adr;
    logic [`PE_WB_DWD-1:0] i_wb_dat;
    logic [`PE_WB_DWD-1:0] o_wb_dat;
    logic                  o_wb_ack;
    logic                  o_irq;

    // host side copies of the pads
    logic [`PE_DWD-1:0] ipad_m [`PE_IPAD_SIZE];
    logic [`PE_DWD-1:0] wpad_m [`PE_WPAD_SIZE];
    logic [`PE_DWD-1:0] ppad_m [`PE_PPAD_SIZE];
    logic [`PE_DWD-1:0] exp_m  [`PE_PPAD_SIZE];

    int              seed;
    int              err_cnt   = 0;
    int              rd_cnt    = 0;
    int              irq_cnt   = 0;
    int              cycle_cnt = 0;
    logic            rd_chk;     // current read is compared
    logic [31:0]     rd_exp;
    logic [7:0]      rd_adr;

    pe_top pe_top_inst (
        .i_clk(i_clk),
        .i_rstn(i_rstn),
        .i_wb_cyc(i_wb_cyc),
        .i_wb_stb(i_wb_stb),
        .i_wb_we(i_wb_we),
        .i_wb_adr(i_wb_adr),
        .i_wb_dat(i_wb_dat),
        .o_wb_dat(o_wb_dat),
        .o_wb_ack(o_wb_ack),
        .o_irq(o_irq)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout, run stopped after %0d cycles", cycle_cnt);
            $display("reads checked %0d, errors %0d", rd_cnt, err_cnt);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    always @(negedge i_clk) begin
        if (o_irq) begin
            irq_cnt <= irq_cnt + 1;
        end
    end

    // ==================================================================
    // bus and interrupt checks
    // ==================================================================
    a_reset_quiet: assert property (
        @(posedge i_clk) $rose(i_rstn) |-> (!o_wb_ack && !o_irq)
    ) else begin
        err_cnt++;
        $display("ack or irq not low when reset was released");
    end

    a_req_ack: assert property (
        @(posedge i_clk) disable iff (!i_rstn)
        (i_wb_cyc && i_wb_stb && !o_wb_ack) |=> o_wb_ack
    ) else begin
        err_cnt++;
        $display("no ack one cycle after request at address %h", i_wb_adr);
    end

    a_ack_single: assert property (
        @(posedge i_clk) disable iff (!i_rstn)
        o_wb_ack |=> !o_wb_ack
    ) else begin
        err_cnt++;
        $display("ack held for more than one cycle");
    end

    a_ack_origin: assert property (
        @(posedge i_clk) disable iff (!i_rstn)
        o_wb_ack |-> $past(i_wb_cyc && i_wb_stb)
    ) else begin
        err_cnt++;
        $display("ack seen without a request before it");
    end

    a_irq_pulse: assert property (
        @(posedge i_clk) disable iff (!i_rstn)
        o_irq |=> !o_irq
    ) else begin
        err_cnt++;
        $display("irq longer than one cycle");
    end

    // read data valid together with ack
    a_rd_data: assert property (
        @(posedge i_clk) disable iff (!i_rstn)
        (i_wb_cyc && i_wb_stb && !i_wb_we && !o_wb_ack && rd_chk) |=>
            (o_wb_ack && (o_wb_dat == rd_exp))
    ) else begin
        err_cnt++;
        $display("Error: o_wb_dat at address %h is %h, expected %h",
                 rd_adr, $sampled(o_wb_dat), rd_exp);
    end

    // ==================================================================
    // helpers
    // ==================================================================
    function automatic logic [7:0] pad_adr(input logic [7:0] base, input int idx);
        return base + 8'(idx * 4);
    endfunction

    function automatic logic [31:0] cfg_word(input int r_len, input int stride,
                                             input int w_len, input pe_num_t num,
                                             input pe_psum_init_t init);
        pe_cfg_t c;
        c           = '0;
        c.r_len     = r_len[4:0];
        c.stride    = stride[2:0];
        c.w_len     = w_len[5:0];
        c.num_t     = num;
        c.init_mode = init;
        return c;
    endfunction

    // psum[j] = init[j] + sum of w[r]*x[j*U + r] mod 2^16
    function automatic logic [15:0] ref_psum(input int j, input int r_len, input int stride,
                                             input bit is_signed, input bit from_buf);
        longint acc;
        longint a;
        longint b;
        int     k;
        acc = from_buf ? ppad_m[j] : 0;
        for (k = 0; k < r_len; k++) begin
            if (is_signed) begin
                a = $signed(ipad_m[j*stride + k]);
                b = $signed(wpad_m[k]);
            end else begin
                a = ipad_m[j*stride + k];
                b = wpad_m[k];
            end
            acc = acc + a * b;
        end
        return acc[15:0];
    endfunction

    task automatic check_eq(input string name, input int got, input int exp);
        assert (got == exp) else begin
            err_cnt++;
            $display("Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic await_ack(input logic [7:0] adr);
        int n;
        n = 0;
        do begin
            @(negedge i_clk);
            n++;
        end while (!o_wb_ack && n < ACK_WAIT);
        if (!o_wb_ack) begin
            err_cnt++;
            $display("no ack for bus access at address %h", adr);
        end
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
        rd_chk   = 1'b0;
    endtask

    task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
        @(negedge i_clk);
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we  = 1'b1;
        i_wb_adr = adr;
        i_wb_dat = dat;
        await_ack(adr);
    endtask

    task automatic wb_read(input logic [7:0] adr, input logic [31:0] exp);
        @(negedge i_clk);
        rd_adr   = adr;
        rd_exp   = exp;
        rd_chk   = 1'b1;
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we  = 1'b0;
        i_wb_adr = adr;
        rd_cnt++;
        await_ack(adr);
    endtask

    // random rows with junk in the upper half of each bus word
    task automatic fill_pads(input int w_len, input int r_len, input bit big_psum);
        logic [31:0] word;
        int          k;
        for (k = 0; k < w_len; k++) begin
            word      = $random(seed);
            ipad_m[k] = word[15:0];
            wb_write(pad_adr(`PE_ADR_IPAD, k), word);
        end
        for (k = 0; k < r_len; k++) begin
            word      = $random(seed);
            wpad_m[k] = word[15:0];
            wb_write(pad_adr(`PE_ADR_WPAD, k), word);
        end
        for (k = 0; k < PAD_BUS_WORDS; k++) begin
            word = $random(seed);
            if (big_psum) begin
                word[15:8] = 8'hff;     // forces the wrap
            end
            ppad_m[k] = word[15:0];
            wb_write(pad_adr(`PE_ADR_PPAD, k), word);
        end
    endtask

    // bus traffic during a run that must not land
    task automatic disturb_run();
        logic [31:0] junk;
        junk = $random(seed);
        wb_read(`PE_ADR_CTRL, 32'h1);           // busy and done cleared
        wb_write(`PE_ADR_CTRL, 32'h1);
        wb_write(`PE_ADR_CFG, junk);
        wb_write(pad_adr(`PE_ADR_IPAD, 8), junk);   // pixel of a later window
        wb_write(pad_adr(`PE_ADR_WPAD, 1), junk);
        wb_write(pad_adr(`PE_ADR_PPAD, 0), junk);
        wb_read(pad_adr(`PE_ADR_PPAD, 0), 32'h0);
    endtask

    task automatic run_conv(input int r_len, input int stride, input int w_len,
                            input pe_num_t num, input pe_psum_init_t init,
                            input bit disturb);
        logic [31:0] cfg;
        int          e_len;
        int          irq0;
        int          j;
        e_len = (w_len - r_len) / stride + 1;
        cfg   = cfg_word(r_len, stride, w_len, num, init);
        wb_write(`PE_ADR_CFG, cfg);
        wb_read(`PE_ADR_CFG, cfg);
        for (j = 0; j < e_len; j++) begin
            exp_m[j] = ref_psum(j, r_len, stride, num == SIGNED_T, init == FROM_BUF);
        end
        irq0 = irq_cnt;
        wb_write(`PE_ADR_CTRL, 32'h1);
        if (disturb) begin
            disturb_run();
        end
        while (irq_cnt == irq0) begin
            @(negedge i_clk);
        end
        wb_read(`PE_ADR_CTRL, 32'h2);           // done and not busy
        for (j = 0; j < e_len; j++) begin
            wb_read(pad_adr(`PE_ADR_PPAD, j), {16'h0, exp_m[j]});
        end
        check_eq("irq pulse count", irq_cnt - irq0, 1);
    endtask

    // ==================================================================
    // stimulus
    // ==================================================================
    initial begin
        logic [31:0] word;
        seed     = 32'hbbda_f5af;
        rd_chk   = 1'b0;
        rd_exp   = '0;
        rd_adr   = '0;
        i_rstn   = 1'b0;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
        i_wb_adr = '0;
        i_wb_dat = '0;
        repeat (8) @(negedge i_clk);
        i_rstn = 1'b1;

        wb_read(`PE_ADR_CTRL, 32'h0);           // idle and not done

        word = $random(seed);
        wb_write(pad_adr(`PE_ADR_PPAD, 5), word);
        wb_read(pad_adr(`PE_ADR_PPAD, 5), {16'h0, word[15:0]});

        fill_pads(16, 3, 1'b0);
        run_conv(3, 1, 16, SIGNED_T, ZERO_INIT, 1'b0);

        fill_pads(16, 4, 1'b1);
        run_conv(4, 2, 16, UNSIGNED_T, FROM_BUF, 1'b0);

        fill_pads(16, 5, 1'b0);
        run_conv(5, 3, 16, SIGNED_T, FROM_BUF, 1'b1);
        wb_read(`PE_ADR_CTRL, 32'h2);           // second start left no run behind

        repeat (2) @(negedge i_clk);
        $display("reads checked %0d, errors %0d", rd_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
pe_pkg.sv
spad_rf.sv
mac_unit.sv
pe_index_cnt.sv
pe_ctrl_fsm.sv
pe_wb_slave.sv
pe_top.sv
tb_pe_top.sv

// ==== Bender.yml ====
package:
  name: pe_row_stationary

sources:
  - include_dirs:
      - .
    files:
      - pe_pkg.sv
      - spad_rf.sv
      - mac_unit.sv
      - pe_index_cnt.sv
      - pe_ctrl_fsm.sv
      - pe_wb_slave.sv
      - pe_top.sv
  - target: any(simulation, test)
    include_dirs:
      - .
    files:
      - tb_pe_top.sv
